/* hw/dither_pkg.sv */
package dither_pkg;

    // ************************************************************
    // word widths
    // ************************************************************

    // gray value after clipping
    localparam int PIX_W = 8;

    // signed quantization error and each weighted share
    localparam int ERR_W = 10;

    // pixel plus share, one bit of headroom before the clip
    localparam int SUM_W = ERR_W + 1;

    // r in the top byte, g in the middle, b in the low byte
    localparam int RGB_W = 24;

    // ************************************************************
    // line timing
    // ************************************************************

    // clocks per line with blanking, small test resolution
    // anything from 12 upward works
    localparam int LINE_TOTAL = 24;

    // blanking clocks needed on each side of the active pixels
    // so that shares beyond the picture edge fall into blanking
    localparam int HBLANK_MIN = 2;

    // delay through one line_fifo, output register included
    localparam int LINE_FIFO_DEPTH = LINE_TOTAL - 5;
    localparam int FIFO_PTR_W = $clog2(LINE_FIFO_DEPTH);

    // fifo word is {vs, hs, de, value}
    localparam int FIFO_W = PIX_W + 3;

    // input sample edge to output, in clocks
    localparam int LATENCY = 2 * LINE_TOTAL + 3;

    // ************************************************************
    // quantizer and kernel shape
    // ************************************************************

    localparam int THRESHOLD = 128;
    localparam int WHITE = 255;

    // kernel reaches HBLANK_MIN pixels sideways
    localparam int TAPS_NEAR = HBLANK_MIN;
    localparam int TAPS_FAR = 2 * HBLANK_MIN + 1;

endpackage

/* hw/diffusion_row.sv */
module diffusion_row
    import dither_pkg::*;
#(
    parameter int TAPS = TAPS_FAR
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [PIX_W-1:0]        value_in,
    input  logic                    de_in,
    input  logic                    hs_in,
    input  logic                    vs_in,
    input  logic signed [ERR_W-1:0] err_in [TAPS],
    output logic [PIX_W-1:0]        value_out,
    output logic                    de_out,
    output logic                    hs_out,
    output logic                    vs_out
);

    // stage 0 is the row entry and stage TAPS-1 its exit
    logic [PIX_W-1:0] stage_val [TAPS];
    logic [PIX_W-1:0] clip_val  [TAPS];
    logic [TAPS-1:0]  stage_de;
    logic [TAPS-1:0]  stage_hs;
    logic [TAPS-1:0]  stage_vs;

    // add one share and saturate to 0..WHITE
    function automatic logic [PIX_W-1:0] clip_add(
        input logic [PIX_W-1:0]        pix,
        input logic signed [ERR_W-1:0] share
    );
        logic signed [SUM_W-1:0] sum;
        sum = $signed({{(SUM_W - PIX_W){1'b0}}, pix})
            + $signed({{(SUM_W - ERR_W){share[ERR_W-1]}}, share});
        if (sum < 0) begin
            return '0;
        end else if (sum > WHITE) begin
            return PIX_W'(WHITE);
        end
        return sum[PIX_W-1:0];
    endfunction

    // share k lands on the pixel held in stage k as it moves on
    always_comb begin
        for (int k = 0; k < TAPS; k++) begin
            clip_val[k] = clip_add(stage_val[k], err_in[k]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < TAPS; k++) begin
                stage_val[k] <= '0;
            end
            stage_de <= '0;
            stage_hs <= '0;
            stage_vs <= '0;
        end else begin
            stage_val[0] <= value_in;
            for (int k = 1; k < TAPS; k++) begin
                stage_val[k] <= clip_val[k-1];
            end
            // sync bits ride along untouched
            stage_de[0] <= de_in;
            stage_hs[0] <= hs_in;
            stage_vs[0] <= vs_in;
            for (int k = 1; k < TAPS; k++) begin
                stage_de[k] <= stage_de[k-1];
                stage_hs[k] <= stage_hs[k-1];
                stage_vs[k] <= stage_vs[k-1];
            end
        end
    end

    // last stage leaves with its own share added
    assign value_out = clip_val[TAPS-1];
    assign de_out    = stage_de[TAPS-1];
    assign hs_out    = stage_hs[TAPS-1];
    assign vs_out    = stage_vs[TAPS-1];

endmodule

/* hw/line_fifo.sv */
module line_fifo
    import dither_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [PIX_W-1:0] value_in,
    input  logic             de_in,
    input  logic             hs_in,
    input  logic             vs_in,
    output logic [PIX_W-1:0] value_out,
    output logic             de_out,
    output logic             hs_out,
    output logic             vs_out
);

    logic [FIFO_W-1:0]     mem [LINE_FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] ptr;
    logic [FIFO_PTR_W-1:0] ptr_next;
    logic [FIFO_PTR_W-1:0] fill_cnt;
    logic                  filled;
    logic [FIFO_W-1:0]     out_q;

    // single wrapping pointer
    assign ptr_next = (ptr == FIFO_PTR_W'(LINE_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;

    // memory has wrapped once, every slot now holds real data
    assign filled = (fill_cnt == FIFO_PTR_W'(LINE_FIFO_DEPTH - 1));

    always_ff @(posedge clk) begin
        mem[ptr] <= {vs_in, hs_in, de_in, value_in};
    end

    // reading the slot ahead of the write gives DEPTH-1 cycles in memory,
    // the output register adds the last one
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr      <= '0;
            fill_cnt <= '0;
            out_q    <= '0;
        end else begin
            ptr <= ptr_next;
            if (!filled) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
            out_q <= filled ? mem[ptr_next] : '0;
        end
    end

    assign {vs_out, hs_out, de_out, value_out} = out_q;

endmodule

/* hw/jjn_quantizer.sv */
module jjn_quantizer
    import dither_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [PIX_W-1:0]        value_in,
    input  logic                    de_in,
    input  logic                    hs_in,
    input  logic                    vs_in,
    output logic signed [ERR_W-1:0] err_cur  [TAPS_NEAR],
    output logic signed [ERR_W-1:0] err_next [TAPS_FAR],
    output logic signed [ERR_W-1:0] err_far  [TAPS_FAR],
    output logic [RGB_W-1:0]        dout,
    output logic                    de_out,
    output logic                    hs_out,
    output logic                    vs_out
);

    // current pixel
    logic [PIX_W-1:0] cur_val;
    logic             cur_de;
    logic             cur_hs;
    logic             cur_vs;

    logic [PIX_W-1:0]        bin_val;
    logic signed [ERR_W-1:0] err;

    // 7/48, 5/48, 3/48 and 1/48 of the error
    logic signed [ERR_W-1:0] w7;
    logic signed [ERR_W-1:0] w5;
    logic signed [ERR_W-1:0] w3;
    logic signed [ERR_W-1:0] w1;

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_val <= '0;
            cur_de  <= 1'b0;
            cur_hs  <= 1'b0;
            cur_vs  <= 1'b0;
        end else begin
            cur_val <= value_in;
            cur_de  <= de_in;
            cur_hs  <= hs_in;
            cur_vs  <= vs_in;
        end
    end

    // ************************************************************
    // binarize and form the error
    // ************************************************************

    assign bin_val = (cur_val >= PIX_W'(THRESHOLD)) ? PIX_W'(WHITE) : '0;

    // range is -127..127
    // blanking positions diffuse nothing
    assign err = cur_de ? $signed({{(ERR_W - PIX_W){1'b0}}, cur_val})
                        - $signed({{(ERR_W - PIX_W){1'b0}}, bin_val})
                        : '0;

    // ************************************************************
    // weights from arithmetic shifts
    // ************************************************************

    // 1/16 + 1/8 - 1/32, close to 7/48
    assign w7 = (err >>> 4) + (err >>> 3) - (err >>> 5);
    // 1/8 - 1/64
    assign w5 = (err >>> 3) - (err >>> 6);
    assign w3 = err >>> 4;
    // 1/64 + 1/128
    assign w1 = (err >>> 6) + (err >>> 7);

    // same line
    // cur_row stage 0 sits two pixels ahead, stage 1 one pixel ahead
    assign err_cur[0] = w5;
    assign err_cur[1] = w7;

    // next line, stage 0 is dx +2 down to stage 4 at dx -2
    assign err_next[0] = w3;
    assign err_next[1] = w5;
    assign err_next[2] = w7;
    assign err_next[3] = w5;
    assign err_next[4] = w3;

    // second line, same dx order
    assign err_far[0] = w1;
    assign err_far[1] = w3;
    assign err_far[2] = w5;
    assign err_far[3] = w3;
    assign err_far[4] = w1;

    // ************************************************************
    // output drive
    // ************************************************************

    // binary result on all three colour bytes, black in blanking
    assign dout   = cur_de ? {3{bin_val}} : '0;
    assign de_out = cur_de;
    assign hs_out = cur_hs;
    assign vs_out = cur_vs;

endmodule

/* hw/jjn_dither_top.sv */
module jjn_dither_top
    import dither_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic [RGB_W-1:0] rgb,
    input  logic             de,
    input  logic             hs,
    input  logic             vs,
    output logic [RGB_W-1:0] dout,
    output logic             de_out,
    output logic             hs_out,
    output logic             vs_out
);

    logic [PIX_W-1:0] gray;

    // input register
    logic [PIX_W-1:0] gray_q;
    logic             de_q;
    logic             hs_q;
    logic             vs_q;

    // far_row exit and its line delay
    logic [PIX_W-1:0] far_val;
    logic             far_de;
    logic             far_hs;
    logic             far_vs;
    logic [PIX_W-1:0] far_dly_val;
    logic             far_dly_de;
    logic             far_dly_hs;
    logic             far_dly_vs;

    // next_row exit and its line delay
    logic [PIX_W-1:0] next_val;
    logic             next_de;
    logic             next_hs;
    logic             next_vs;
    logic [PIX_W-1:0] next_dly_val;
    logic             next_dly_de;
    logic             next_dly_hs;
    logic             next_dly_vs;

    // cur_row exit into the quantizer
    logic [PIX_W-1:0] cur_val;
    logic             cur_de;
    logic             cur_hs;
    logic             cur_vs;

    logic signed [ERR_W-1:0] err_far  [TAPS_FAR];
    logic signed [ERR_W-1:0] err_next [TAPS_FAR];
    logic signed [ERR_W-1:0] err_cur  [TAPS_NEAR];

    // b/4 + g/2 + r/4, tops out at 253 so no carry out of 8 bits
    assign gray = {2'b00, rgb[7:2]} + {1'b0, rgb[15:9]} + {2'b00, rgb[23:18]};

    always_ff @(posedge clk) begin
        if (rst) begin
            gray_q <= '0;
            de_q   <= 1'b0;
            hs_q   <= 1'b0;
            vs_q   <= 1'b0;
        end else begin
            gray_q <= gray;
            de_q   <= de;
            hs_q   <= hs;
            vs_q   <= vs;
        end
    end

    // ************************************************************
    // pipeline, oldest pixel at the quantizer end
    // ************************************************************

    // second following line
    diffusion_row #(.TAPS(TAPS_FAR)) far_row (
        .clk(clk), .rst(rst), .value_in(gray_q), .de_in(de_q), .hs_in(hs_q), .vs_in(vs_q),
        .err_in(err_far), .value_out(far_val), .de_out(far_de), .hs_out(far_hs),
        .vs_out(far_vs)
    );

    line_fifo far_fifo (
        .clk(clk), .rst(rst), .value_in(far_val), .de_in(far_de), .hs_in(far_hs),
        .vs_in(far_vs), .value_out(far_dly_val), .de_out(far_dly_de),
        .hs_out(far_dly_hs), .vs_out(far_dly_vs)
    );

    // first following line
    diffusion_row #(.TAPS(TAPS_FAR)) next_row (
        .clk(clk), .rst(rst), .value_in(far_dly_val), .de_in(far_dly_de),
        .hs_in(far_dly_hs), .vs_in(far_dly_vs), .err_in(err_next), .value_out(next_val),
        .de_out(next_de), .hs_out(next_hs), .vs_out(next_vs)
    );

    line_fifo next_fifo (
        .clk(clk), .rst(rst), .value_in(next_val), .de_in(next_de), .hs_in(next_hs),
        .vs_in(next_vs), .value_out(next_dly_val), .de_out(next_dly_de),
        .hs_out(next_dly_hs), .vs_out(next_dly_vs)
    );

    // two pixels ahead on the current line
    diffusion_row #(.TAPS(TAPS_NEAR)) cur_row (
        .clk(clk), .rst(rst), .value_in(next_dly_val), .de_in(next_dly_de),
        .hs_in(next_dly_hs), .vs_in(next_dly_vs), .err_in(err_cur), .value_out(cur_val),
        .de_out(cur_de), .hs_out(cur_hs), .vs_out(cur_vs)
    );

    jjn_quantizer quantizer_i (
        .clk(clk), .rst(rst), .value_in(cur_val), .de_in(cur_de), .hs_in(cur_hs),
        .vs_in(cur_vs), .err_cur(err_cur), .err_next(err_next), .err_far(err_far),
        .dout(dout), .de_out(de_out), .hs_out(hs_out), .vs_out(vs_out)
    );

endmodule

/* tb/jjn_dither_assertions.sv */
module jjn_dither_assertions
    import dither_pkg::*;
(
    input logic                    clk,
    input logic                    rst,
    input logic                    cur_de,
    input logic signed [ERR_W-1:0] err_cur  [TAPS_NEAR],
    input logic signed [ERR_W-1:0] err_next [TAPS_FAR],
    input logic signed [ERR_W-1:0] err_far  [TAPS_FAR],
    input logic [RGB_W-1:0]        dout,
    input logic                    de_out,
    input logic                    hs_out,
    input logic                    vs_out
);
    timeunit 1ns;
    timeprecision 1ps;

    // any of the twelve shares nonzero
    logic any_share;

    always_comb begin
        any_share = 1'b0;
        for (int k = 0; k < TAPS_NEAR; k++) begin
            any_share = any_share | (err_cur[k] != '0);
        end
        for (int k = 0; k < TAPS_FAR; k++) begin
            any_share = any_share | (err_next[k] != '0) | (err_far[k] != '0);
        end
    end

    // blanking diffuses nothing
    share_quiet: assert property (@(posedge clk) disable iff (rst) !cur_de |-> !any_share)
        else $error("error share nonzero while de is low");

    // same binary value on all three bytes
    binary_out: assert property (@(posedge clk) disable iff (rst) (dout == '0) || (dout == '1))
        else $error("dout is not a binary colour");

    reset_quiet: assert property (@(posedge clk)
        rst |=> (dout == '0) && !de_out && !hs_out && !vs_out)
        else $error("outputs not cleared by reset");

endmodule

bind jjn_quantizer jjn_dither_assertions assertions_i (
    .clk(clk), .rst(rst), .cur_de(cur_de), .err_cur(err_cur), .err_next(err_next),
    .err_far(err_far), .dout(dout), .de_out(de_out), .hs_out(hs_out), .vs_out(vs_out)
);

/* tb/jjn_dither_tb.sv */
module jjn_dither_tb
    import dither_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // test frame geometry
    // 16 active pixels with 4 blanking clocks on each side of a line
    localparam int H_BLANK    = 4;
    localparam int V_ACTIVE   = 10;
    localparam int V_TOTAL    = 13;
    localparam int FRAME_CLKS = LINE_TOTAL * V_TOTAL;
    localparam int FRAMES     = 6;
    localparam int SEED       = 52675;
    localparam int RST_CLKS   = 8;
    localparam int TOTAL_CLKS = RST_CLKS + FRAMES * FRAME_CLKS + LATENCY + 4;

    logic             clk;
    logic             rst;
    logic [RGB_W-1:0] rgb;
    logic             de;
    logic             hs;
    logic             vs;
    logic [RGB_W-1:0] dout;
    logic             de_out;
    logic             hs_out;
    logic             vs_out;

    // reference model indexed by clocks since the last reset release
    int               pix   [TOTAL_CLKS];
    logic [2:0]       psync [TOTAL_CLKS];
    string            pname [TOTAL_CLKS];
    int               pos;
    int               q_idx;
    // expected outputs after the current edge get compared on the next one
    logic             exp_valid = 1'b0;
    logic [RGB_W-1:0] exp_pix;
    logic [2:0]       exp_sync;
    logic [PIX_W-1:0] exp_bin;
    string            exp_name;
    string            test_name;

    jjn_dither_top dut_i (
        .clk(clk), .rst(rst), .rgb(rgb), .de(de), .hs(hs), .vs(vs),
        .dout(dout), .de_out(de_out), .hs_out(hs_out), .vs_out(vs_out)
    );

    always #10 clk = ~clk;

    // ************************************************************
    // checks
    // ************************************************************

    task automatic check_pixel(input string name, input logic [RGB_W-1:0] exp,
                               input logic [RGB_W-1:0] act);
        if (act !== exp) begin
            $display("** Error %s: dout expected %06h actual %06h", name, exp, act);
            $display("Something failed");
            $fatal(1, "output pixel mismatch");
        end
    endtask

    task automatic check_sync(input string name, input logic [2:0] exp,
                              input logic [2:0] act);
        if (act !== exp) begin
            $display("** Error %s: {de,hs,vs} expected %03b actual %03b", name, exp, act);
            $display("Something failed");
            $fatal(1, "sync output mismatch");
        end
    endtask

    // ************************************************************
    // reference model
    // ************************************************************

    function automatic int saturate(input int v);
        if (v < 0) begin
            return 0;
        end
        return (v > WHITE) ? WHITE : v;
    endfunction

    // b/4 + g/2 + r/4
    function automatic int gray_of(input logic [RGB_W-1:0] c);
        return (int'(c[7:0]) >> 2) + (int'(c[15:8]) >> 1) + (int'(c[23:16]) >> 2);
    endfunction

    // quantize position q and push its error into later positions
    task automatic spread_error(input int q);
        int e;
        int w7;
        int w5;
        int w3;
        int w1;
        int next_w [5];
        int far_w  [5];
        int tgt;
        e  = pix[q] - ((pix[q] >= THRESHOLD) ? WHITE : 0);
        w7 = (e >>> 4) + (e >>> 3) - (e >>> 5);
        w5 = (e >>> 3) - (e >>> 6);
        w3 = e >>> 4;
        w1 = (e >>> 6) + (e >>> 7);
        next_w = '{w3, w5, w7, w5, w3};
        far_w  = '{w1, w3, w5, w3, w1};
        // same line
        pix[q + 1] = saturate(pix[q + 1] + w7);
        pix[q + 2] = saturate(pix[q + 2] + w5);
        // next and second line, dx from -2 to +2
        for (int dx = -2; dx <= 2; dx++) begin
            tgt      = q + LINE_TOTAL + dx;
            pix[tgt] = saturate(pix[tgt] + next_w[dx + 2]);
            tgt      = q + 2 * LINE_TOTAL + dx;
            pix[tgt] = saturate(pix[tgt] + far_w[dx + 2]);
        end
    endtask

    // inputs and outputs are both read before this edge updates them
    always @(posedge clk) begin
        if (exp_valid) begin
            check_sync("sync_delay", exp_sync, {de_out, hs_out, vs_out});
            check_pixel(exp_name, exp_pix, dout);
        end
        if (rst) begin
            pos      = 0;
            exp_pix  = '0;
            exp_sync = '0;
            exp_name = "reset_quiet";
        end else begin
            pix[pos]   = gray_of(rgb);
            psync[pos] = {de, hs, vs};
            pname[pos] = test_name;
            q_idx      = pos - LATENCY;
            if (q_idx < 0) begin
                // pipeline still holds the zeros left by reset
                exp_pix  = '0;
                exp_sync = '0;
                exp_name = "reset_quiet";
            end else begin
                // de low sends no error
                if (psync[q_idx][2]) begin
                    spread_error(q_idx);
                end
                exp_bin  = (pix[q_idx] >= THRESHOLD) ? PIX_W'(WHITE) : '0;
                exp_sync = psync[q_idx];
                exp_pix  = psync[q_idx][2] ? {3{exp_bin}} : '0;
                exp_name = psync[q_idx][2] ? pname[q_idx] : "blanking";
            end
            pos++;
        end
        exp_valid = 1'b1;
    end

    // ************************************************************
    // stimulus
    // ************************************************************

    // one frame with rst pulsed at the start of rst_line, no pulse if rst_line is negative
    task automatic drive_frame(input bit random_rgb, input int rst_line);
        for (int line = 0; line < V_TOTAL; line++) begin
            for (int x = 0; x < LINE_TOTAL; x++) begin
                @(posedge clk);
                rst <= (line == rst_line) && (x < RST_CLKS);
                rgb <= random_rgb ? RGB_W'($urandom) : '0;
                de  <= (line < V_ACTIVE) && (x >= H_BLANK) && (x < LINE_TOTAL - H_BLANK);
                hs  <= (x < 2);
                vs  <= (line == V_ACTIVE);
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        clk       = 1'b0;
        rst       = 1'b1;
        rgb       = '0;
        de        = 1'b0;
        hs        = 1'b0;
        vs        = 1'b0;
        test_name = "reset_quiet";
        repeat (RST_CLKS) @(posedge clk);
        rst       <= 1'b0;
        test_name <= "black_field";
        drive_frame(1'b0, -1);
        test_name <= "random_diffusion";
        repeat (3) drive_frame(1'b1, -1);
        test_name <= "mid_run_reset";
        drive_frame(1'b1, 4);
        drive_frame(1'b1, -1);
        // drain the last line through the pipeline
        for (int k = 0; k < LATENCY + 4; k++) begin
            @(posedge clk);
            rgb <= '0;
            de  <= 1'b0;
            hs  <= 1'b0;
            vs  <= 1'b0;
        end
        $display("Everything OK");
        $finish;
    end

    // twice the full stimulus length
    initial begin
        #(2 * TOTAL_CLKS * 20);
        $display("Something failed");
        $fatal(1, "run did not finish in time");
    end

endmodule

/* verilog.f */
hw/dither_pkg.sv
hw/diffusion_row.sv
hw/line_fifo.sv
hw/jjn_quantizer.sv
hw/jjn_dither_top.sv
tb/jjn_dither_assertions.sv
tb/jjn_dither_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
LINTFLAGS = --lint-only --timing -Wall
TOP       = jjn_dither_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
